/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_video_capture
FILELIST = filelist.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -q "test failed" $(LOG); then exit 1; fi
	@if ! grep -q "test passed" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD) $(LOG)

/* filelist.f */
+incdir+logic
logic/pixel_pkg.sv
logic/mem_pkg.sv
logic/pixel_packer.sv
logic/frame_addr_gen.sv
logic/burst_buffer.sv
logic/write_arbiter.sv
logic/video_capture_top.sv
tests/tb_video_capture.sv

/* logic/burst_buffer.sv */
/*
 * burst buffer
 * 32-word FIFO in front of the write arbiter, raises burst_req with a
 * captured address once 16 unclaimed words are held
 * a rden pulse streams those 16 words, first beat two cycles later
 */
`timescale 1ns/1ps
`default_nettype none

`include "video_defs.svh"

module burst_buffer
    import pixel_pkg::*;
    import mem_pkg::*;
#(
    parameter burst_addr_t base_addr = '0
) (
    input  wire logic        clk_50M,
    input  wire logic        reset,
    input  wire logic        vs,
    input  wire logic        word_vld,
    input  wire pixel_word_t word,
    input  wire logic        burst_rden,     // one-cycle grant
    output logic             burst_req,
    output burst_addr_t      burst_req_addr, // held while burst_req is up
    output logic             burst_vld,
    output pixel_word_t      burst_data,
    output frame_idx_t       wr_frame
);

    localparam int ptr_w  = $clog2(`FIFO_WORDS);
    localparam int fill_w = ptr_w + 1;
    localparam int beat_w = $clog2(`BURST_LEN);

    pixel_word_t       fifo_mem [`FIFO_WORDS];
    logic [ptr_w-1:0]  wr_ptr, rd_ptr;
    logic [fill_w-1:0] fill;           // words held
    logic [fill_w-1:0] unclaimed;      // words not yet behind a request
    logic              fifo_full, wr_en, claim, burst_taken;
    logic              rd_run;         // reading the granted burst
    logic [beat_w-1:0] rd_cnt;
    burst_addr_t       next_addr;

    assign fifo_full   = (fill == fill_w'(`FIFO_WORDS));
    assign wr_en       = word_vld && !fifo_full;     // full drops the word
    assign claim       = !burst_req && (unclaimed >= fill_w'(`BURST_LEN));
    assign burst_taken = claim;

    frame_addr_gen #(.base_addr(base_addr)) u_addr (
        .clk_50M     (clk_50M),
        .reset       (reset),
        .vs          (vs),
        .burst_taken (burst_taken),
        .frame       (wr_frame),
        .burst_addr  (next_addr)
    );

    always_ff @(posedge clk_50M) begin
        if (reset) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            fill      <= '0;
            unclaimed <= '0;
            burst_req <= 1'b0;
            rd_run    <= 1'b0;
            rd_cnt    <= '0;
            burst_vld <= 1'b0;
        end else begin
            fill      <= fill + fill_w'(wr_en) - fill_w'(rd_run);
            unclaimed <= unclaimed + fill_w'(wr_en)
                       - (claim ? fill_w'(`BURST_LEN) : '0);
            burst_vld <= rd_run;                 // read data lands a cycle later
            if (wr_en) wr_ptr <= wr_ptr + 1'b1;
            if (claim) begin
                burst_req <= 1'b1;
            end else if (burst_rden) begin
                burst_req <= 1'b0;
                rd_run    <= 1'b1;               // starts the cycle after rden
                rd_cnt    <= '0;
            end
            if (rd_run) begin
                rd_ptr <= rd_ptr + 1'b1;
                rd_cnt <= rd_cnt + 1'b1;
                if (rd_cnt == beat_w'(`BURST_LEN - 1)) rd_run <= 1'b0;
            end
        end
    end

    // storage and payload
    always_ff @(posedge clk_50M) begin
        if (wr_en) fifo_mem[wr_ptr] <= word;
        if (rd_run) burst_data <= fifo_mem[rd_ptr];
        if (claim) burst_req_addr <= next_addr;  // address frozen for this burst
    end

    // packer rate against arbiter drain keeps the FIFO from overflowing
    assert property (@(posedge clk_50M) disable iff (reset)
        word_vld |-> !fifo_full);

    // arbiter only grants a request that is up
    assert property (@(posedge clk_50M) disable iff (reset)
        burst_rden |-> burst_req);

endmodule

`default_nettype wire

/* logic/frame_addr_gen.sv */
/*
 * frame address generator
 * rotates the three-frame write index on each rising edge of vs and
 * counts bursts inside the current frame
 * burst_addr = base + frame * FRAME_BURSTS + burst count
 */
`timescale 1ns/1ps
`default_nettype none

`include "video_defs.svh"

module frame_addr_gen
    import mem_pkg::*;
#(
    parameter burst_addr_t base_addr = '0  // begin address of this source
) (
    input  wire logic   clk_50M,
    input  wire logic   reset,
    input  wire logic   vs,
    input  wire logic   burst_taken,     // advance to the next burst
    output frame_idx_t  frame,
    output burst_addr_t burst_addr
);

    localparam int          cnt_w      = $clog2(`FRAME_BURSTS);
    localparam burst_addr_t frame_span = burst_addr_t'(`FRAME_BURSTS);

    logic             vs_d;
    logic             vs_rise;
    logic [cnt_w-1:0] burst_cnt;

    assign vs_rise = vs && !vs_d;

    always_ff @(posedge clk_50M) begin
        if (reset) begin
            vs_d      <= 1'b0;
            frame     <= FRAME_0;
            burst_cnt <= '0;
        end else begin
            vs_d <= vs;
            if (vs_rise) begin
                burst_cnt <= '0;                 // new frame wins over taken
                case (frame)
                    FRAME_0: frame <= FRAME_1;
                    FRAME_1: frame <= FRAME_2;
                    default: frame <= FRAME_0;   // 2 wraps to 0
                endcase
            end else if (burst_taken) begin
                burst_cnt <= burst_cnt + 1'b1;   // wraps at FRAME_BURSTS
            end
        end
    end

    assign burst_addr = base_addr
                      + burst_addr_t'(frame) * frame_span
                      + burst_addr_t'(burst_cnt);

endmodule

`default_nettype wire

/* logic/mem_pkg.sv */
/*
 * memory side types
 * burst address, rotating frame index, source id used as the
 * grant encoding, and the write arbiter states
 */
`default_nettype none

`include "video_defs.svh"

package mem_pkg;

    typedef logic [`ADDR_W-1:0] burst_addr_t;  // counts bursts, not bytes

    typedef enum logic [1:0] {
        FRAME_0,
        FRAME_1,
        FRAME_2
    } frame_idx_t;

    typedef enum logic [1:0] {
        SRC_HDMI,                  // highest priority out of reset
        SRC_CAM_A,
        SRC_CAM_B
    } source_id_t;

    typedef enum logic [1:0] {
        ARB_IDLE,                  // looking for a request
        ARB_GAP,                   // one cycle after a burst
        ARB_XFER                   // beats on the port
    } arb_state_t;

endpackage

`default_nettype wire

/* logic/pixel_packer.sv */
/*
 * pixel packer
 * shifts ten valid pixels into one 240-bit word and flags it for a
 * single cycle, first pixel ending up in slot 0
 * vs high throws away a partial word and holds the packer idle
 */
`timescale 1ns/1ps
`default_nettype none

`include "video_defs.svh"

module pixel_packer
    import pixel_pkg::*;
(
    input  wire logic        clk_50M,
    input  wire logic        reset,
    input  wire logic        vs,        // frame start level
    input  wire logic        de,        // pixel strobe
    input  wire rgb888_t     pixel,
    output logic             word_vld,  // one cycle per packed word
    output pixel_word_t      word
);

    localparam int slot_w = $clog2(`WORD_PIXELS);

    logic [slot_w-1:0]  slot_cnt;      // next free slot
    logic [`WORD_W-1:0] shift_sr;      // newest pixel enters at the top
    logic               take;
    logic               last_slot;

    assign take      = de && !vs;      // de ignored during vs
    assign last_slot = (slot_cnt == slot_w'(`WORD_PIXELS - 1));

    always_ff @(posedge clk_50M) begin
        if (reset) begin
            slot_cnt <= '0;
            word_vld <= 1'b0;
        end else begin
            word_vld <= take && last_slot;       // word ready next cycle
            if (vs) begin
                slot_cnt <= '0;                  // drop partial word
            end else if (take) begin
                slot_cnt <= last_slot ? '0 : slot_cnt + 1'b1;
            end
        end
    end

    // payload shift
    always_ff @(posedge clk_50M) begin
        if (take) begin
            shift_sr <= {pixel, shift_sr[`WORD_W-1:`PIXEL_W]};
        end
    end

    assign word = pixel_word_t'(shift_sr);  // stable while word_vld is up

    // a word needs ten strobes, so two in a row means a broken slot count
    assert property (@(posedge clk_50M) disable iff (reset)
        word_vld |=> !word_vld);

endmodule

`default_nettype wire

/* logic/pixel_pkg.sv */
/*
 * pixel formats
 * rgb888 and rgb565 pixels and the ten-pixel memory word,
 * slot 0 of the word in the low bits
 */
`default_nettype none

`include "video_defs.svh"

package pixel_pkg;

    typedef struct packed {
        logic [`PIXEL_W/3-1:0] r;  // red in the top byte
        logic [`PIXEL_W/3-1:0] g;
        logic [`PIXEL_W/3-1:0] b;
    } rgb888_t;

    typedef struct packed {
        logic [4:0] r;
        logic [5:0] g;             // green keeps the extra bit
        logic [4:0] b;
    } rgb565_t;

    typedef rgb888_t [`WORD_PIXELS-1:0] pixel_word_t;  // 240 bits

endpackage

`default_nettype wire

/* logic/video_capture_top.sv */
/*
 * video capture top
 * hdmi rgb888 and two rgb565 cameras, each through a packer and a
 * burst buffer with its own base address, merged by the write arbiter
 * onto one memory write port
 */
`timescale 1ns/1ps
`default_nettype none

`include "video_defs.svh"

module video_capture_top
    import pixel_pkg::*;
    import mem_pkg::*;
(
    input  wire logic    clk_50M,
    input  wire logic    reset,
    input  wire logic    hdmi_vs,
    input  wire logic    hdmi_de,
    input  wire rgb888_t hdmi_rgb,
    input  wire logic    cam_a_vs,
    input  wire logic    cam_a_de,
    input  wire rgb565_t cam_a_rgb565,
    input  wire logic    cam_b_vs,
    input  wire logic    cam_b_de,
    input  wire rgb565_t cam_b_rgb565,
    output frame_idx_t   hdmi_frame,
    output frame_idx_t   cam_a_frame,
    output frame_idx_t   cam_b_frame,
    output logic         mem_wr_start,
    output burst_addr_t  mem_wr_addr,
    output source_id_t   mem_wr_src,
    output logic         mem_wr_vld,
    output pixel_word_t  mem_wr_data,
    output logic         mem_wr_last
);

    // high bits from the camera, low bits zero
    function automatic rgb888_t expand_565(rgb565_t p);
        rgb888_t q;
        q.r = {p.r, 3'b000};
        q.g = {p.g, 2'b00};
        q.b = {p.b, 3'b000};
        return q;
    endfunction

    logic [`NUM_SRC-1:0] ch_vs, ch_de, ch_word_vld;
    logic [`NUM_SRC-1:0] ch_req, ch_vld, ch_rden;
    rgb888_t             ch_pix      [`NUM_SRC];
    pixel_word_t         ch_word     [`NUM_SRC];
    burst_addr_t         ch_req_addr [`NUM_SRC];
    pixel_word_t         ch_data     [`NUM_SRC];
    frame_idx_t          ch_frame    [`NUM_SRC];

    assign ch_vs = {cam_b_vs, cam_a_vs, hdmi_vs};   // index = source id
    assign ch_de = {cam_b_de, cam_a_de, hdmi_de};
    assign ch_pix[SRC_HDMI]  = hdmi_rgb;
    assign ch_pix[SRC_CAM_A] = expand_565(cam_a_rgb565);
    assign ch_pix[SRC_CAM_B] = expand_565(cam_b_rgb565);

    for (genvar i = 0; i < `NUM_SRC; i++) begin : g_chan
        localparam burst_addr_t chan_base =
            (i == 0) ? burst_addr_t'(`BASE_HDMI)  :
            (i == 1) ? burst_addr_t'(`BASE_CAM_A) : burst_addr_t'(`BASE_CAM_B);

        pixel_packer u_packer (
            .clk_50M (clk_50M), .reset (reset),
            .vs (ch_vs[i]), .de (ch_de[i]), .pixel (ch_pix[i]),
            .word_vld (ch_word_vld[i]), .word (ch_word[i])
        );

        burst_buffer #(.base_addr(chan_base)) u_buffer (
            .clk_50M (clk_50M), .reset (reset), .vs (ch_vs[i]),
            .word_vld (ch_word_vld[i]), .word (ch_word[i]),
            .burst_rden (ch_rden[i]), .burst_req (ch_req[i]),
            .burst_req_addr (ch_req_addr[i]), .burst_vld (ch_vld[i]),
            .burst_data (ch_data[i]), .wr_frame (ch_frame[i])
        );
    end

    write_arbiter u_arbiter (
        .clk_50M (clk_50M), .reset (reset),
        .burst_req (ch_req), .burst_req_addr (ch_req_addr),
        .burst_vld (ch_vld), .burst_data (ch_data), .burst_rden (ch_rden),
        .mem_wr_start (mem_wr_start), .mem_wr_addr (mem_wr_addr),
        .mem_wr_src (mem_wr_src), .mem_wr_vld (mem_wr_vld),
        .mem_wr_data (mem_wr_data), .mem_wr_last (mem_wr_last)
    );

    assign hdmi_frame  = ch_frame[SRC_HDMI];   // handed on to the reader
    assign cam_a_frame = ch_frame[SRC_CAM_A];
    assign cam_b_frame = ch_frame[SRC_CAM_B];

endmodule

`default_nettype wire

/* logic/video_defs.svh */
/*
 * video capture sizes
 * pixel, word and burst dimensions of the frame-buffer write path,
 * the burst address width and the per-source frame regions
 */
`ifndef VIDEO_DEFS_SVH
`define VIDEO_DEFS_SVH

// pixel and word geometry
`define PIXEL_W       24     // rgb888
`define WORD_PIXELS   10     // pixels per memory word
`define WORD_W        240    // memory word width

// burst buffering
`define BURST_LEN     16     // words per burst
`define FIFO_WORDS    32     // two bursts deep

// burst addressing, in whole bursts
`define ADDR_W        16
`define FRAME_BURSTS  64     // bursts reserved per frame per source
`define NUM_SRC       3      // hdmi, cam a, cam b

// begin address of each source, three frames each
`define BASE_HDMI     0
`define BASE_CAM_A    192
`define BASE_CAM_B    384

`endif

/* logic/write_arbiter.sv */
/*
 * write arbiter
 * round-robin over the three burst buffers, one burst at a time
 * grants with a one-cycle rden, then registers the 16 beats onto the
 * memory write port with a start strobe and a last-beat flag
 */
`timescale 1ns/1ps
`default_nettype none

`include "video_defs.svh"

module write_arbiter
    import pixel_pkg::*;
    import mem_pkg::*;
(
    input  wire logic                clk_50M,
    input  wire logic                reset,
    input  wire logic [`NUM_SRC-1:0] burst_req,
    input  wire burst_addr_t         burst_req_addr [`NUM_SRC],
    input  wire logic [`NUM_SRC-1:0] burst_vld,
    input  wire pixel_word_t         burst_data [`NUM_SRC],
    output logic [`NUM_SRC-1:0]      burst_rden,
    output logic                     mem_wr_start,  // cycle before first beat
    output burst_addr_t              mem_wr_addr,
    output source_id_t               mem_wr_src,
    output logic                     mem_wr_vld,
    output pixel_word_t              mem_wr_data,
    output logic                     mem_wr_last    // beat 16
);

    localparam int beat_w = $clog2(`BURST_LEN);

    arb_state_t        state;
    source_id_t        grant;          // last granted source
    source_id_t        pick;
    logic              pick_ok;
    logic              rden_d;         // rden delayed, lines up start
    logic [beat_w-1:0] beat_cnt;

    // next requester after grant, order hdmi, cam a, cam b
    always_comb begin
        int unsigned idx;
        pick    = grant;
        pick_ok = 1'b0;
        for (int k = `NUM_SRC; k >= 1; k--) begin   // k = 1 checked last, wins
            idx = (int'(grant) + k) % `NUM_SRC;
            if (burst_req[idx]) begin
                pick    = source_id_t'(idx);
                pick_ok = 1'b1;
            end
        end
    end

    always_ff @(posedge clk_50M) begin
        if (reset) begin
            state        <= ARB_IDLE;
            grant        <= SRC_CAM_B;   // so hdmi goes first
            burst_rden   <= '0;
            rden_d       <= 1'b0;
            beat_cnt     <= '0;
            mem_wr_start <= 1'b0;
            mem_wr_vld   <= 1'b0;
            mem_wr_last  <= 1'b0;
        end else begin
            burst_rden   <= '0;
            rden_d       <= |burst_rden;
            mem_wr_start <= rden_d;
            mem_wr_vld   <= 1'b0;
            mem_wr_last  <= 1'b0;
            case (state)
                ARB_IDLE: begin
                    if (|burst_rden) begin
                        state <= ARB_XFER;       // rden out, wait for beats
                    end else if (pick_ok) begin
                        burst_rden <= `NUM_SRC'(1) << pick;
                        grant      <= pick;
                    end
                end
                ARB_XFER: begin
                    if (burst_vld[grant]) begin
                        mem_wr_vld <= 1'b1;
                        beat_cnt   <= beat_cnt + 1'b1;
                        if (beat_cnt == beat_w'(`BURST_LEN - 1)) begin
                            mem_wr_last <= 1'b1;
                            state       <= ARB_GAP;
                        end
                    end
                end
                ARB_GAP:  state <= ARB_IDLE;     // buffer settles burst_req
                default:  state <= ARB_IDLE;
            endcase
        end
    end

    // port payload
    always_ff @(posedge clk_50M) begin
        if (|burst_rden) begin
            mem_wr_addr <= burst_req_addr[grant];  // req still up this cycle
            mem_wr_src  <= grant;
        end
        mem_wr_data <= burst_data[grant];
    end

    // single grant, and never while a burst is in flight
    assert property (@(posedge clk_50M) disable iff (reset)
        (|burst_rden) |-> ($onehot(burst_rden) && state == ARB_IDLE));

endmodule

`default_nettype wire

/* tests/tb_video_capture.sv */
/*
 * video capture testbench
 * rows of a stimulus table feed the three sources in parallel, a model
 * packs, expands and addresses the expected bursts per source, and a
 * monitor on the memory port matches each burst against its queue
 */
`timescale 1ns/1ps
`default_nettype none

`include "video_defs.svh"

module tb_video_capture
    import pixel_pkg::*;
    import mem_pkg::*;
();

    localparam int n_rows = 7;

    logic        clk_50M, reset;
    logic        hdmi_vs, hdmi_de, cam_a_vs, cam_a_de, cam_b_vs, cam_b_de;
    rgb888_t     hdmi_rgb;
    rgb565_t     cam_a_rgb565, cam_b_rgb565;
    frame_idx_t  hdmi_frame, cam_a_frame, cam_b_frame;
    logic        mem_wr_start, mem_wr_vld, mem_wr_last;
    burst_addr_t mem_wr_addr;
    source_id_t  mem_wr_src;
    pixel_word_t mem_wr_data;

    string       row_name [n_rows];
    int          row_cnt  [n_rows][3];     // pixels per source
    logic [2:0]  row_vs   [n_rows];        // vs pulse first, bit = source
    logic [2:0]  row_half [n_rows];        // de every other cycle
    logic        row_rr   [n_rows];        // simultaneous requests, check order

    int                 frame_m [3], bcnt_m [3], slot_m [3], pend_cnt [3];
    logic [`WORD_W-1:0] cur_word  [3];
    logic [`WORD_W-1:0] pend_word [3][`BURST_LEN];  // whole words not yet a burst
    logic [`ADDR_W-1:0] exp_addr  [3][$];
    logic [`WORD_W-1:0] exp_words [3][$];
    int                 errors, bursts_seen, last_src, cycle_cnt, timeout_limit;
    logic               mon_busy, rr_on;

    video_capture_top dut0 (
        .clk_50M (clk_50M), .reset (reset),
        .hdmi_vs (hdmi_vs), .hdmi_de (hdmi_de), .hdmi_rgb (hdmi_rgb),
        .cam_a_vs (cam_a_vs), .cam_a_de (cam_a_de), .cam_a_rgb565 (cam_a_rgb565),
        .cam_b_vs (cam_b_vs), .cam_b_de (cam_b_de), .cam_b_rgb565 (cam_b_rgb565),
        .hdmi_frame (hdmi_frame), .cam_a_frame (cam_a_frame),
        .cam_b_frame (cam_b_frame), .mem_wr_start (mem_wr_start),
        .mem_wr_addr (mem_wr_addr), .mem_wr_src (mem_wr_src),
        .mem_wr_vld (mem_wr_vld), .mem_wr_data (mem_wr_data),
        .mem_wr_last (mem_wr_last)
    );

    initial begin
        clk_50M = 1'b0;
        forever #10 clk_50M = ~clk_50M;    // 50 MHz
    end

    task automatic check_value(input string name, input logic [`WORD_W-1:0] got,
                               input logic [`WORD_W-1:0] exp);
        if (got !== exp) begin
            $display("FAILED %s: got %0h expected %0h", name, got, exp);
            errors++;
        end
    endtask

    // camera high bits kept, low bits zero
    function automatic logic [23:0] widen_rgb565(input logic [15:0] p);
        return {p[15:11], 3'b000, p[10:5], 2'b00, p[4:0], 3'b000};
    endfunction

    function automatic int base_of(input int s);
        case (s)
            0:       return `BASE_HDMI;
            1:       return `BASE_CAM_A;
            default: return `BASE_CAM_B;
        endcase
    endfunction

    // slot 0 first, ten slots a word, sixteen words a burst
    function automatic void model_take(input int s, input logic [23:0] pix);
        cur_word[s][slot_m[s]*`PIXEL_W +: `PIXEL_W] = pix;
        if (slot_m[s] == `WORD_PIXELS - 1) begin
            slot_m[s] = 0;
            pend_word[s][pend_cnt[s]] = cur_word[s];
            pend_cnt[s]++;
            if (pend_cnt[s] == `BURST_LEN) begin
                exp_addr[s].push_back(`ADDR_W'(base_of(s)
                                      + frame_m[s] * `FRAME_BURSTS + bcnt_m[s]));
                for (int k = 0; k < `BURST_LEN; k++) exp_words[s].push_back(pend_word[s][k]);
                pend_cnt[s] = 0;
                bcnt_m[s]   = (bcnt_m[s] + 1) % `FRAME_BURSTS;
            end
        end else begin
            slot_m[s]++;
        end
    endfunction

    task automatic load_row(input int r, input string name, input int nh, na, nb,
                            input logic [2:0] vs, half, input logic rr);
        row_name[r] = name;
        row_cnt[r][0] = nh;
        row_cnt[r][1] = na;
        row_cnt[r][2] = nb;
        row_vs[r]   = vs;
        row_half[r] = half;
        row_rr[r]   = rr;
    endtask

    task automatic drive_src(input int s, input logic de, input logic [23:0] pix);
        case (s)
            0: begin
                hdmi_de  = de;
                hdmi_rgb = pix;
            end
            1: begin
                cam_a_de     = de;
                cam_a_rgb565 = pix[15:0];
            end
            default: begin
                cam_b_de     = de;
                cam_b_rgb565 = pix[15:0];
            end
        endcase
    endtask

    task automatic check_frames();
        check_value("hdmi_frame", hdmi_frame, frame_m[0]);
        check_value("cam_a_frame", cam_a_frame, frame_m[1]);
        check_value("cam_b_frame", cam_b_frame, frame_m[2]);
    endtask

    task automatic pulse_vs(input logic [2:0] mask);
        @(negedge clk_50M);
        hdmi_vs  = mask[0];
        cam_a_vs = mask[1];
        cam_b_vs = mask[2];
        repeat (2) @(negedge clk_50M);
        {cam_b_vs, cam_a_vs, hdmi_vs} = 3'b000;
        for (int s = 0; s < 3; s++) begin
            if (mask[s]) begin
                frame_m[s] = (frame_m[s] + 1) % 3;  // 0, 1, 2, 0
                bcnt_m[s]  = 0;
                slot_m[s]  = 0;                     // partial word dropped
            end
        end
        @(negedge clk_50M);
        check_frames();
    endtask

    task automatic feed(input int s, input int n, input logic half);
        logic [23:0] raw;
        for (int i = 0; i < n; i++) begin
            @(negedge clk_50M);
            raw = 24'($urandom());
            drive_src(s, 1'b1, raw);
            model_take(s, (s == 0) ? raw : widen_rgb565(raw[15:0]));
            if (half) begin
                @(negedge clk_50M);
                drive_src(s, 1'b0, raw);
            end
        end
        @(negedge clk_50M);
        drive_src(s, 1'b0, 24'h0);
    endtask

    task automatic drain();
        int pending;
        do begin
            @(negedge clk_50M);
            pending = 0;
            for (int s = 0; s < 3; s++) pending += exp_words[s].size();
        end while (pending != 0 || mon_busy);
        repeat (4) @(negedge clk_50M);   // room for a stray burst to show
    endtask

    task automatic take_burst();
        int s;
        s = int'(mem_wr_src);
        if (s > 2 || exp_addr[s].size() == 0) begin
            $display("burst from source %0d arrived with none expected", s);
            errors++;
        end else begin
            mon_busy = 1'b1;
            if (rr_on) check_value("mem_wr_src", s, (last_src + 1) % 3);
            check_value("mem_wr_addr", mem_wr_addr, exp_addr[s].pop_front());
            last_src = s;
            for (int b = 0; b < `BURST_LEN; b++) begin
                @(negedge clk_50M);
                check_value("mem_wr_vld", mem_wr_vld, 1'b1);
                check_value("mem_wr_start", mem_wr_start, 1'b0);
                check_value("mem_wr_data", mem_wr_data, exp_words[s].pop_front());
                check_value("mem_wr_last", mem_wr_last, b == `BURST_LEN - 1);
            end
            bursts_seen++;
            mon_busy = 1'b0;
        end
    endtask

    // port monitor, outputs settled at the falling edge
    initial begin
        forever begin
            @(negedge clk_50M);
            if (!reset && mem_wr_start) begin
                take_burst();
            end else if (!reset && (mem_wr_vld || mem_wr_last)) begin
                $display("beat on the memory port outside a burst");
                errors++;
            end
        end
    end

    initial begin
        @(posedge clk_50M);
        while (cycle_cnt < timeout_limit) begin
            @(posedge clk_50M);
            cycle_cnt++;
        end
        $display("timeout after %0d cycles with bursts still outstanding", cycle_cnt);
        $display("test failed");
        $finish;
    end

    initial begin
        int err_before;
        void'($urandom(32'h60c6));
        reset = 1'b1;
        {hdmi_vs, hdmi_de, cam_a_vs, cam_a_de, cam_b_vs, cam_b_de} = '0;
        hdmi_rgb     = '0;
        cam_a_rgb565 = '0;
        cam_b_rgb565 = '0;
        mon_busy = 1'b0;
        rr_on    = 1'b0;
        last_src = 2;                             // arbiter starts after cam b
        load_row(0, "single hdmi burst",        160,   0,   0, 3'b000, 3'b000, 1'b0);
        load_row(1, "camera rgb565 expansion",    0, 160, 165, 3'b000, 3'b100, 1'b0);
        load_row(2, "vs mid word",              323, 160, 160, 3'b111, 3'b000, 1'b0);
        load_row(3, "consecutive addresses",    480,   0,   0, 3'b001, 3'b001, 1'b0);
        load_row(4, "all sources at once",      320, 320, 320, 3'b111, 3'b000, 1'b1);
        load_row(5, "all sources half duty",    160, 160, 160, 3'b000, 3'b111, 1'b1);
        load_row(6, "frame wrap",                 0,   0,   0, 3'b111, 3'b000, 1'b0);
        timeout_limit = 200;
        for (int r = 0; r < n_rows; r++)
            for (int s = 0; s < 3; s++) timeout_limit += 4 * row_cnt[r][s];
        repeat (3) @(negedge clk_50M);
        reset = 1'b0;
        check_value("mem_wr_vld", mem_wr_vld, 1'b0);   // idle after reset
        check_value("mem_wr_start", mem_wr_start, 1'b0);
        check_value("mem_wr_last", mem_wr_last, 1'b0);
        check_frames();
        for (int r = 0; r < n_rows; r++) begin
            err_before = errors;
            rr_on = row_rr[r];
            if (row_vs[r] != 3'b000) pulse_vs(row_vs[r]);
            fork
                feed(0, row_cnt[r][0], row_half[r][0]);
                feed(1, row_cnt[r][1], row_half[r][1]);
                feed(2, row_cnt[r][2], row_half[r][2]);
            join
            drain();
            check_frames();
            $display("row %0d %s: %0d errors", r, row_name[r], errors - err_before);
        end
        $display("rows %0d, bursts checked %0d, errors %0d", n_rows, bursts_seen, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
